//--- dv/obi_phase_observer_tb.sv
`timescale 1ns/1ps

module obi_phase_observer_tb
  import obi_obs_cfg_pkg::*;
  import obi_obs_ctrl_pkg::*;
;

  localparam int HOLD_CYCLES = 5;
  localparam int RAND_CYCLES = 300;
  localparam int SAT_CYCLES  = 20;
  // rough cycle budget of all phases, used by the watchdog
  localparam int STIM_CYCLES = 10 + 2 * NUM_BUSES * (HOLD_CYCLES + 3) + RAND_CYCLES
                               + 2 * SAT_CYCLES + NUM_BUSES * 8 + 12 + 40 + 10;
  localparam int WATCHDOG_NS = (STIM_CYCLES + 100) * 40;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            orphan_clr;
  logic                            pc_set;
  pc_mux_e                         pc_mux;
  logic                            rvfi_valid;
  logic [NUM_BUSES-1:0]            bus_req;
  logic [NUM_BUSES-1:0]            bus_gnt;
  logic [NUM_BUSES-1:0]            bus_rvalid;
  logic [NUM_BUSES-1:0]            bus_rready;
  logic [NUM_BUSES-1:0]            addr_ph_cont_o;
  logic [NUM_BUSES-1:0]            resp_ph_cont_o;
  logic [NUM_BUSES-1:0]            orphan_rsp_o;
  logic [NUM_BUSES-1:0][CNT_W-1:0] outstanding_o;
  logic [TOT_W-1:0]                total_outstanding_o;
  logic                            req_after_exception_o;
  int                              errors;
  logic [31:0]                     lcg_state;

  tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) u_clk (.clk_o(clk_i), .rst_no(rst_ni));

  obi_phase_observer u_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .orphan_clr_i(orphan_clr),
    .pc_set_i(pc_set), .pc_mux_i(pc_mux), .rvfi_valid_i(rvfi_valid),
    .bus_req_i(bus_req), .bus_gnt_i(bus_gnt),
    .bus_rvalid_i(bus_rvalid), .bus_rready_i(bus_rready),
    .addr_ph_cont_o(addr_ph_cont_o), .resp_ph_cont_o(resp_ph_cont_o),
    .orphan_rsp_o(orphan_rsp_o), .outstanding_o(outstanding_o),
    .total_outstanding_o(total_outstanding_o),
    .req_after_exception_o(req_after_exception_o)
  );

  // --------------------
  // reference model
  // --------------------

  logic [NUM_BUSES-1:0]            addr_d1_q, addr_exp_q, resp_d1_q, resp_exp_q;
  logic [NUM_BUSES-1:0][CNT_W-1:0] cnt_q, cnt_exp_q, cnt_next;
  logic [NUM_BUSES-1:0]            orphan_now, orphan_d1_q, orphan_d2_q, orphan_exp_q;
  logic [TOT_W-1:0]                total_exp_q;
  logic                            trap_active_q, prev_gnt_q, trap_exp_q;
  logic                            exc_now, fresh_req;
  logic [1:0]                      rst_hist_q;

  // counter rule for one bus, grants add and accepted responses remove
  function automatic logic [CNT_W-1:0] count_step(input logic [CNT_W-1:0] cnt,
                                                  input logic addr_fire, input logic rsp_fire);
    if (addr_fire && !rsp_fire && cnt != {CNT_W{1'b1}}) begin
      return cnt + CNT_W'(1);
    end
    if (rsp_fire && !addr_fire && cnt != '0) begin
      return cnt - CNT_W'(1);
    end
    return cnt;
  endfunction

  function automatic logic [TOT_W-1:0] total_of(input logic [NUM_BUSES-1:0][CNT_W-1:0] cnt);
    logic [TOT_W-1:0] sum;
    sum = '0;
    for (int b = 0; b < NUM_BUSES; b++) begin
      sum = sum + TOT_W'(cnt[b]);
    end
    return sum;
  endfunction

  always_comb begin
    for (int b = 0; b < NUM_BUSES; b++) begin
      cnt_next[b]   = count_step(cnt_q[b], bus_req[b] & bus_gnt[b],
                                 bus_rvalid[b] & bus_rready[b]);
      orphan_now[b] = bus_rvalid[b] & bus_rready[b] & ~(bus_req[b] & bus_gnt[b])
                      & (cnt_q[b] == '0);
    end
    exc_now   = pc_set & ((pc_mux == PC_TRAP_EXC) | (pc_mux == PC_TRAP_DBE));
    fresh_req = bus_req[DATA_BUS_IDX] & prev_gnt_q;
  end

  // phase results see one extra stage for the input sampler
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {addr_d1_q, addr_exp_q, resp_d1_q, resp_exp_q} <= '0;
      {cnt_q, cnt_exp_q, total_exp_q} <= '0;
      {orphan_d1_q, orphan_d2_q, orphan_exp_q} <= '0;
      {trap_active_q, prev_gnt_q, trap_exp_q} <= '0;
      rst_hist_q <= '0;
    end else begin
      rst_hist_q  <= {rst_hist_q[0], 1'b1};
      addr_d1_q   <= bus_req & ~bus_gnt;
      addr_exp_q  <= addr_d1_q;
      resp_d1_q   <= bus_rvalid & ~bus_rready;
      resp_exp_q  <= resp_d1_q;
      cnt_q       <= cnt_next;
      cnt_exp_q   <= cnt_q;
      total_exp_q <= total_of(cnt_q);
      // the orphan pulse passes sampler and monitor before the sticky flag
      orphan_d1_q <= orphan_now;
      orphan_d2_q <= orphan_d1_q;
      // a clear beats a pulse that lands on the same edge
      orphan_exp_q <= orphan_clr ? '0 : (orphan_exp_q | orphan_d2_q);
      // the trap side works on the raw data bus with no sampler stage
      prev_gnt_q <= bus_gnt[DATA_BUS_IDX];
      if (exc_now) begin
        trap_active_q <= 1'b1;
        if (fresh_req) trap_exp_q <= 1'b1;
      end else if (rvfi_valid) begin
        trap_active_q <= 1'b0;
        trap_exp_q    <= 1'b0;
      end else if (trap_active_q && fresh_req) begin
        trap_exp_q <= 1'b1;
      end
    end
  end

  // --------------------
  // checks
  // --------------------

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  assert property (@(posedge clk_i) addr_ph_cont_o == addr_exp_q)
    else report_mismatch("addr_ph_cont_o differs from the model");
  assert property (@(posedge clk_i) resp_ph_cont_o == resp_exp_q)
    else report_mismatch("resp_ph_cont_o differs from the model");
  assert property (@(posedge clk_i) outstanding_o == cnt_exp_q)
    else report_mismatch("outstanding_o differs from the model counters");
  assert property (@(posedge clk_i) total_outstanding_o == total_exp_q)
    else report_mismatch("total_outstanding_o is not the sum of the lanes");
  assert property (@(posedge clk_i) orphan_rsp_o == orphan_exp_q)
    else report_mismatch("orphan_rsp_o differs from the model flags");
  assert property (@(posedge clk_i) req_after_exception_o == trap_exp_q)
    else report_mismatch("req_after_exception_o differs from the model");
  // during reset and the first cycle after it every output is low
  assert property (@(posedge clk_i) (rst_ni && (&rst_hist_q)) ||
                   !(|{addr_ph_cont_o, resp_ph_cont_o, orphan_rsp_o, outstanding_o,
                       total_outstanding_o, req_after_exception_o}))
    else report_mismatch("an output is not zero around reset");

  // --------------------
  // stimulus
  // --------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // inputs change a little after the rising edge
  task automatic step_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic drive_idle();
    {bus_req, bus_gnt, bus_rvalid, bus_rready} = '0;
    orphan_clr = 1'b0;
    pc_set     = 1'b0;
    pc_mux     = PC_BOOT;
    rvfi_valid = 1'b0;
  endtask

  task automatic run_addr_phases();
    for (int b = 0; b < NUM_BUSES; b++) begin
      bus_req[b] = 1'b1;
      repeat (HOLD_CYCLES) step_cycle();
      // the grant finally ends the phase and leaves one address outstanding
      bus_gnt[b] = 1'b1;
      step_cycle();
      drive_idle();
      repeat (2) step_cycle();
    end
  endtask

  task automatic run_resp_phases();
    for (int b = 0; b < NUM_BUSES; b++) begin
      bus_rvalid[b] = 1'b1;
      repeat (HOLD_CYCLES) step_cycle();
      bus_rready[b] = 1'b1;
      step_cycle();
      drive_idle();
      repeat (2) step_cycle();
    end
  endtask

  task automatic run_random_traffic();
    for (int i = 0; i < RAND_CYCLES; i++) begin
      lcg_state  = lcg_next(lcg_state);
      bus_req    = lcg_state[NUM_BUSES-1:0];
      bus_gnt    = lcg_state[NUM_BUSES+7:8];
      bus_rvalid = lcg_state[NUM_BUSES+11:12];
      bus_rready = lcg_state[NUM_BUSES+15:16];
      orphan_clr = (lcg_state[31:28] == 4'h0);
      pc_set     = lcg_state[24] & lcg_state[25];
      pc_mux     = pc_mux_e'(lcg_state[23:21]);
      rvfi_valid = lcg_state[26] & lcg_state[27];
      step_cycle();
    end
    drive_idle();
  endtask

  task automatic run_saturation();
    // grants only, well past the counter ceiling
    bus_req = '1;
    bus_gnt = '1;
    repeat (SAT_CYCLES) step_cycle();
    drive_idle();
    // responses only, draining every counter back to zero
    bus_rvalid = '1;
    bus_rready = '1;
    repeat (SAT_CYCLES) step_cycle();
    drive_idle();
  endtask

  task automatic run_orphans();
    orphan_clr = 1'b1;
    step_cycle();
    drive_idle();
    for (int b = 0; b < NUM_BUSES; b++) begin
      bus_rvalid[b] = 1'b1;
      bus_rready[b] = 1'b1;
      step_cycle();
      drive_idle();
      repeat (4) step_cycle();
      orphan_clr = 1'b1;
      step_cycle();
      drive_idle();
      step_cycle();
    end
    // clear lands on the same edge as the new pulse and must win
    bus_rvalid[0] = 1'b1;
    bus_rready[0] = 1'b1;
    step_cycle();
    drive_idle();
    step_cycle();
    orphan_clr = 1'b1;
    step_cycle();
    drive_idle();
    repeat (4) step_cycle();
  endtask

  // one trap from the given source with fresh data requests around it
  task automatic take_trap(input pc_mux_e src);
    bus_req[DATA_BUS_IDX] = 1'b1;
    bus_gnt[DATA_BUS_IDX] = 1'b1;
    step_cycle();
    pc_set = 1'b1;
    pc_mux = src;
    step_cycle();
    pc_set = 1'b0;
    repeat (2) step_cycle();
    drive_idle();
    step_cycle();
    rvfi_valid = 1'b1;
    step_cycle();
    drive_idle();
    step_cycle();
  endtask

  task automatic run_traps();
    take_trap(PC_TRAP_EXC);
    take_trap(PC_TRAP_DBE);
    take_trap(PC_TRAP_IRQ);
    take_trap(PC_JUMP);
    // the request arrives only in the cycle after the trap
    bus_gnt[DATA_BUS_IDX] = 1'b1;
    pc_set = 1'b1;
    pc_mux = PC_TRAP_DBE;
    step_cycle();
    drive_idle();
    bus_req[DATA_BUS_IDX] = 1'b1;
    step_cycle();
    drive_idle();
    repeat (2) step_cycle();
    rvfi_valid = 1'b1;
    step_cycle();
    drive_idle();
    repeat (2) step_cycle();
  endtask

  initial begin
    errors    = 0;
    lcg_state = 32'h7168_d06f;
    drive_idle();
    // open phases and a taken trap while reset is held, none may reach an output
    bus_req    = '1;
    bus_rvalid = '1;
    pc_set     = 1'b1;
    pc_mux     = PC_TRAP_EXC;
    @(posedge rst_ni);
    drive_idle();
    repeat (3) step_cycle();
    run_addr_phases();
    run_resp_phases();
    run_random_traffic();
    run_saturation();
    run_orphans();
    run_traps();
    // let the pipeline empty so the last inputs are checked too
    repeat (6) step_cycle();
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // ends a run that takes far longer than the stimulus needs
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the stimulus did not finish within %0d ns", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule : obi_phase_observer_tb

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  // free running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset is held for a fixed number of rising edges and released just after one
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule : tb_clock_gen

//--- obi_phase_observer.f
source/obi_obs_cfg_pkg.sv
source/obi_obs_ctrl_pkg.sv
source/obi_bus_if.sv
source/obi_phase_status_if.sv
source/obi_bus_sampler.sv
source/obi_phase_monitor.sv
source/obi_phase_collector.sv
source/trap_req_tracker.sv
source/obi_phase_observer.sv
dv/tb_clock_gen.sv
dv/obi_phase_observer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the observer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module obi_phase_observer_tb \
  -f obi_phase_observer.f \
  -o sim_obi_phase_observer

./obj_dir/sim_obi_phase_observer | tee sim.log

# the log decides the result, not the exit status of the simulator
if grep -q "^Done: no errors$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- source/obi_bus_if.sv
`timescale 1ns/1ps

// one sampled OBI handshake channel
// the sampler drives it and a phase monitor reads it
interface obi_bus_if;

  // address phase request and grant
  logic req;
  logic gnt;

  // response phase valid and ready
  logic rvalid;
  logic rready;

  modport source (
    output req,
    output gnt,
    output rvalid,
    output rready
  );

  modport sink (
    input req,
    input gnt,
    input rvalid,
    input rready
  );

endinterface : obi_bus_if

//--- source/obi_bus_sampler.sv
`timescale 1ns/1ps

module obi_bus_sampler #(
  parameter int NUM_BUSES = obi_obs_cfg_pkg::NUM_BUSES
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [NUM_BUSES-1:0] bus_req_i,
  input  logic [NUM_BUSES-1:0] bus_gnt_i,
  input  logic [NUM_BUSES-1:0] bus_rvalid_i,
  input  logic [NUM_BUSES-1:0] bus_rready_i,
  obi_bus_if.source            bus_o [NUM_BUSES]
);

  logic [NUM_BUSES-1:0] req_q;
  logic [NUM_BUSES-1:0] gnt_q;
  logic [NUM_BUSES-1:0] rvalid_q;
  logic [NUM_BUSES-1:0] rready_q;

  // --------------------
  // input stage
  // --------------------

  // a single flop stage for every bus so all monitors see the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q    <= '0;
      gnt_q    <= '0;
      rvalid_q <= '0;
      rready_q <= '0;
    end else begin
      req_q    <= bus_req_i;
      gnt_q    <= bus_gnt_i;
      rvalid_q <= bus_rvalid_i;
      rready_q <= bus_rready_i;
    end
  end

  // spread each bus lane onto its own channel
  for (genvar b = 0; b < NUM_BUSES; b++) begin : g_lane
    assign bus_o[b].req    = req_q[b];
    assign bus_o[b].gnt    = gnt_q[b];
    assign bus_o[b].rvalid = rvalid_q[b];
    assign bus_o[b].rready = rready_q[b];
  end

endmodule : obi_bus_sampler

//--- source/obi_obs_cfg_pkg.sv
package obi_obs_cfg_pkg;

  // --------------------
  // observer sizing
  // --------------------

  // number of OBI channels watched by one observer instance
  parameter int NUM_BUSES = 4;

  // width of each per-bus outstanding counter, which saturates at all ones
  parameter int CNT_W = 4;

  // width of the summed outstanding total
  // it holds NUM_BUSES times the all-ones counter value
  parameter int TOT_W = 6;

  // index of the bus that carries data accesses for trap tracking
  parameter int DATA_BUS_IDX = 0;

endpackage : obi_obs_cfg_pkg

//--- source/obi_obs_ctrl_pkg.sv
package obi_obs_ctrl_pkg;

  // --------------------
  // core control encodings
  // --------------------

  // program counter source selected by the controller FSM
  // only the two exception sources count as a taken exception
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_DBE = 3'd5,
    PC_TRAP_IRQ = 3'd6,
    PC_DRET     = 3'd7
  } pc_mux_e;

  // trap tracker FSM states
  // active means a trap was taken and nothing has retired since
  typedef enum logic {
    TRAP_IDLE   = 1'b0,
    TRAP_ACTIVE = 1'b1
  } trap_state_e;

endpackage : obi_obs_ctrl_pkg

//--- source/obi_phase_collector.sv
`timescale 1ns/1ps

module obi_phase_collector #(
  parameter int NUM_BUSES = obi_obs_cfg_pkg::NUM_BUSES,
  parameter int CNT_W     = obi_obs_cfg_pkg::CNT_W,
  parameter int TOT_W     = obi_obs_cfg_pkg::TOT_W
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            orphan_clr_i,
  obi_phase_status_if.sink                status_i [NUM_BUSES],
  output logic [NUM_BUSES-1:0]            addr_ph_cont_o,
  output logic [NUM_BUSES-1:0]            resp_ph_cont_o,
  output logic [NUM_BUSES-1:0]            orphan_rsp_o,
  output logic [NUM_BUSES-1:0][CNT_W-1:0] outstanding_o,
  output logic [TOT_W-1:0]                total_outstanding_o
);

  logic [NUM_BUSES-1:0] orphan_pulse;
  logic [NUM_BUSES-1:0] orphan_q;
  logic [TOT_W-1:0]     total_sum;

  // --------------------
  // lane packing
  // --------------------

  // the interface array needs a constant index, hence the generate loop
  for (genvar b = 0; b < NUM_BUSES; b++) begin : g_pack
    assign addr_ph_cont_o[b] = status_i[b].addr_ph_cont;
    assign resp_ph_cont_o[b] = status_i[b].resp_ph_cont;
    assign outstanding_o[b]  = status_i[b].outstanding;
    assign orphan_pulse[b]   = status_i[b].orphan_rsp;
  end

  // sticky orphan flags
  // a clear in the same cycle as a new pulse wins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      orphan_q <= '0;
    end else if (orphan_clr_i) begin
      orphan_q <= '0;
    end else begin
      orphan_q <= orphan_q | orphan_pulse;
    end
  end

  assign orphan_rsp_o = orphan_q;

  // sum of all lanes, no extra stage so it lines up with the vectors
  always_comb begin
    total_sum = '0;
    for (int b = 0; b < NUM_BUSES; b++) begin
      total_sum = total_sum + TOT_W'(outstanding_o[b]);
    end
  end

  assign total_outstanding_o = total_sum;

endmodule : obi_phase_collector

//--- source/obi_phase_monitor.sv
`timescale 1ns/1ps

module obi_phase_monitor #(
  parameter int CNT_W = obi_obs_cfg_pkg::CNT_W
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  obi_bus_if.sink            bus_i,
  obi_phase_status_if.source status_o
);

  // counter ceiling, the counter never wraps past it
  localparam logic [CNT_W-1:0] CntMax = '1;

  logic             addr_done;
  logic             rsp_done;
  logic             addr_ph_cont_q;
  logic             resp_ph_cont_q;
  logic [CNT_W-1:0] outstanding_q;
  logic             orphan_rsp_q;

  // --------------------
  // phase completion
  // --------------------

  // an address phase ends when the request is granted
  assign addr_done = bus_i.req & bus_i.gnt;

  // a response phase ends when the valid response is accepted
  assign rsp_done = bus_i.rvalid & bus_i.rready;

  // flags for phases that did not finish in this cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cont_q <= 1'b0;
      resp_ph_cont_q <= 1'b0;
    end else begin
      addr_ph_cont_q <= bus_i.req & ~bus_i.gnt;
      resp_ph_cont_q <= bus_i.rvalid & ~bus_i.rready;
    end
  end

  // --------------------
  // outstanding tracking
  // --------------------

  // an address and a response in the same cycle cancel out and the count holds
  // the orphan case also requires that no address completes alongside
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
      orphan_rsp_q  <= 1'b0;
    end else begin
      orphan_rsp_q <= rsp_done & ~addr_done & (outstanding_q == '0);
      if (addr_done && !rsp_done) begin
        // saturate rather than wrap when many grants pile up
        if (outstanding_q != CntMax) begin
          outstanding_q <= outstanding_q + 1'b1;
        end
      end else if (rsp_done && !addr_done && (outstanding_q != '0)) begin
        outstanding_q <= outstanding_q - 1'b1;
      end
    end
  end

  // results to the collector
  assign status_o.addr_ph_cont = addr_ph_cont_q;
  assign status_o.resp_ph_cont = resp_ph_cont_q;
  assign status_o.outstanding  = outstanding_q;
  assign status_o.orphan_rsp   = orphan_rsp_q;

endmodule : obi_phase_monitor

//--- source/obi_phase_observer.sv
`timescale 1ns/1ps

module obi_phase_observer
  import obi_obs_ctrl_pkg::*;
#(
  parameter int  NUM_BUSES    = obi_obs_cfg_pkg::NUM_BUSES,
  parameter int  CNT_W        = obi_obs_cfg_pkg::CNT_W,
  parameter int  DATA_BUS_IDX = obi_obs_cfg_pkg::DATA_BUS_IDX,
  // enough bits for every counter sitting at its ceiling
  localparam int TOT_W        = $clog2(NUM_BUSES * (2 ** CNT_W - 1) + 1)
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            orphan_clr_i,
  input  logic                            pc_set_i,
  input  pc_mux_e                         pc_mux_i,
  input  logic                            rvfi_valid_i,
  input  logic [NUM_BUSES-1:0]            bus_req_i,
  input  logic [NUM_BUSES-1:0]            bus_gnt_i,
  input  logic [NUM_BUSES-1:0]            bus_rvalid_i,
  input  logic [NUM_BUSES-1:0]            bus_rready_i,
  output logic [NUM_BUSES-1:0]            addr_ph_cont_o,
  output logic [NUM_BUSES-1:0]            resp_ph_cont_o,
  output logic [NUM_BUSES-1:0]            orphan_rsp_o,
  output logic [NUM_BUSES-1:0][CNT_W-1:0] outstanding_o,
  output logic [TOT_W-1:0]                total_outstanding_o,
  output logic                            req_after_exception_o
);

  // --------------------
  // channels
  // --------------------

  // sampled handshakes, one channel per bus
  obi_bus_if bus_if [NUM_BUSES] ();

  // monitor results, one channel per bus
  obi_phase_status_if #(.CNT_W(CNT_W)) status_if [NUM_BUSES] ();

  // --------------------
  // phase observation
  // --------------------

  // aligns all buses to one registered cycle
  obi_bus_sampler #(
    .NUM_BUSES(NUM_BUSES)
  ) u_sampler (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bus_req_i   (bus_req_i),
    .bus_gnt_i   (bus_gnt_i),
    .bus_rvalid_i(bus_rvalid_i),
    .bus_rready_i(bus_rready_i),
    .bus_o       (bus_if)
  );

  // identical monitors, one per bus
  for (genvar b = 0; b < NUM_BUSES; b++) begin : g_mon
    obi_phase_monitor #(
      .CNT_W(CNT_W)
    ) u_monitor (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .bus_i   (bus_if[b]),
      .status_o(status_if[b])
    );
  end

  // packs monitor results and holds the orphan flags
  obi_phase_collector #(
    .NUM_BUSES(NUM_BUSES),
    .CNT_W    (CNT_W),
    .TOT_W    (TOT_W)
  ) u_collector (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .orphan_clr_i       (orphan_clr_i),
    .status_i           (status_if),
    .addr_ph_cont_o     (addr_ph_cont_o),
    .resp_ph_cont_o     (resp_ph_cont_o),
    .orphan_rsp_o       (orphan_rsp_o),
    .outstanding_o      (outstanding_o),
    .total_outstanding_o(total_outstanding_o)
  );

  // --------------------
  // trap tracking
  // --------------------

  // watches the raw data bus, not the sampled copy, for its one cycle latency
  trap_req_tracker u_trap_tracker (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .pc_set_i             (pc_set_i),
    .pc_mux_i             (pc_mux_i),
    .rvfi_valid_i         (rvfi_valid_i),
    .data_req_i           (bus_req_i[DATA_BUS_IDX]),
    .data_gnt_i           (bus_gnt_i[DATA_BUS_IDX]),
    .req_after_exception_o(req_after_exception_o)
  );

endmodule : obi_phase_observer

//--- source/obi_phase_status_if.sv
`timescale 1ns/1ps

// results of one phase monitor, read by the collector
interface obi_phase_status_if #(
  parameter int CNT_W = obi_obs_cfg_pkg::CNT_W
);

  // multi-cycle phase indicators
  logic             addr_ph_cont;
  logic             resp_ph_cont;
  // granted addresses still waiting for their response
  logic [CNT_W-1:0] outstanding;
  // single cycle pulse for a response with nothing outstanding
  logic             orphan_rsp;

  modport source (
    output addr_ph_cont,
    output resp_ph_cont,
    output outstanding,
    output orphan_rsp
  );

  modport sink (
    input addr_ph_cont,
    input resp_ph_cont,
    input outstanding,
    input orphan_rsp
  );

endinterface : obi_phase_status_if

//--- source/trap_req_tracker.sv
`timescale 1ns/1ps

module trap_req_tracker
  import obi_obs_ctrl_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    pc_set_i,
  input  pc_mux_e pc_mux_i,
  input  logic    rvfi_valid_i,
  input  logic    data_req_i,
  input  logic    data_gnt_i,
  output logic    req_after_exception_o
);

  trap_state_e state_q;
  logic        data_gnt_q;
  logic        exc_taken;
  logic        req_after_exc_q;

  // interrupts, returns and jumps also set the pc but are not exceptions
  assign exc_taken = pc_set_i & ((pc_mux_i == PC_TRAP_EXC) | (pc_mux_i == PC_TRAP_DBE));

  // --------------------
  // trap FSM
  // --------------------

  // the previous grant marks a data address phase that just completed,
  // so a request now is a fresh one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= TRAP_IDLE;
      data_gnt_q      <= 1'b0;
      req_after_exc_q <= 1'b0;
    end else begin
      data_gnt_q <= data_gnt_i;
      if (exc_taken) begin
        state_q <= TRAP_ACTIVE;
        if (data_req_i && data_gnt_q) begin
          req_after_exc_q <= 1'b1;
        end
      end else if (rvfi_valid_i) begin
        // retirement ends the trap window
        state_q         <= TRAP_IDLE;
        req_after_exc_q <= 1'b0;
      end else if ((state_q == TRAP_ACTIVE) && data_req_i && data_gnt_q) begin
        req_after_exc_q <= 1'b1;
      end
    end
  end

  assign req_after_exception_o = req_after_exc_q;

endmodule : trap_req_tracker
